// ==== bench/tb_cpu_top.sv ====
/* Testbench for the serially loaded CPU: loads programs over rxd,
   decodes txd frames and checks the bytes, modes and led */
`default_nettype none
`timescale 1ns/1ps

module tb_cpu_top import cpu_pkg::*; ();

	localparam int bit_cycles = 8;
	localparam int frame_cycles = 10 * bit_cycles;
	// Received frames 9+62+14+46+42+34, transmitted frames 1+8+2+11+6+1
	localparam int total_frames = 236;
	localparam int run_limit = 4000;

	logic clk;
	logic rstn;
	logic rxd;
	logic txd;
	logic [7:0] led;

	logic [7:0] rx_q[$];
	logic [31:0] prog[$];
	logic [7:0] expect_q[$];
	logic in_frame = 1'b0;
	int value_errs = 0;
	int other_errs = 0;
	logic was_halted;
	logic [7:0] halt_led;

	cpu_top #(.clk_per_bit(bit_cycles)) dut0 (
		.clk(clk), .rstn(rstn), .rxd(rxd), .txd(txd), .led(led)
	);

	always #5 clk = ~clk;

	initial begin
		#((total_frames * frame_cycles + 2000) * 10);
		$display("Watchdog expired before all tests completed");
		$display("*** FAILED ***");
		$finish;
	end

	// ======================================================================
	// Instruction assembly
	// ======================================================================
	function automatic logic [31:0] reg_form(opcode_t op, logic [4:0] rd, logic [4:0] rs,
			logic [4:0] rt);
		return {op, rd, rs, rt, 11'd0};
	endfunction

	function automatic logic [31:0] imm_form(opcode_t op, logic [4:0] rd, logic [4:0] rs,
			logic [15:0] imm);
		return {op, rd, rs, imm};
	endfunction

	function automatic logic [31:0] out_word(logic [4:0] rs);
		return imm_form(op_out, 5'd0, rs, 16'd0);
	endfunction

	function automatic logic [31:0] halt_word();
		return imm_form(op_halt, 5'd0, 5'd0, 16'd0);
	endfunction

	function automatic logic [31:0] sext16(logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	// ======================================================================
	// Checks and serial helpers
	// ======================================================================
	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			value_errs++;
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic report_failure(input string msg);
		other_errs++;
		$display("%s", msg);
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rstn = 1'b0;
		rxd = 1'b1;
		repeat (8) @(negedge clk);
		rstn = 1'b1;
		rx_q.delete();
	endtask

	// One 8N1 frame, LSB first
	task automatic send_byte(input logic [7:0] b);
		@(negedge clk);
		rxd = 1'b0;
		repeat (bit_cycles) @(negedge clk);
		for (int i = 0; i < 8; i++) begin
			rxd = b[i];
			repeat (bit_cycles) @(negedge clk);
		end
		rxd = 1'b1;
		repeat (bit_cycles) @(negedge clk);
	endtask

	task automatic wait_for_mode(input mode_t m, input int limit);
		int n;
		n = 0;
		while (led[7:6] !== m && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (led[7:6] !== m)
			report_failure($sformatf("Timed out waiting for the CPU to reach mode %0d", m));
	endtask

	task automatic wait_for_bytes(input int count, input int limit);
		int n;
		n = 0;
		while (rx_q.size() < count && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (rx_q.size() < count)
			report_failure($sformatf("Timed out waiting for %0d bytes on txd", count));
	endtask

	task automatic wait_line_quiet();
		int quiet;
		quiet = 0;
		while (quiet < 3 * bit_cycles) begin
			@(negedge clk);
			if (txd === 1'b1 && !in_frame)
				quiet++;
			else
				quiet = 0;
		end
	endtask

	// Start handshake, load prog, run to HALT and compare the output bytes
	task automatic run_program();
		send_byte(start_byte);
		wait_for_bytes(1, 2 * frame_cycles);
		if (rx_q.size() > 0)
			compare_value("echo byte", rx_q.pop_front(), start_byte);
		compare_value("led mode after start", led[7:6], mode_load);
		send_byte(8'(prog.size()));
		for (int i = 0; i < prog.size(); i++) begin
			for (int k = 0; k < 4; k++)
				send_byte(prog[i][8*k +: 8]);
		end
		wait_for_mode(mode_halt, run_limit);
		wait_line_quiet();
		compare_value("txd byte count", rx_q.size(), expect_q.size());
		for (int i = 0; i < expect_q.size() && i < rx_q.size(); i++)
			compare_value($sformatf("txd byte %0d", i), rx_q[i], expect_q[i]);
	endtask

	// Frame decoder, samples near the middle of each bit
	always begin : frame_monitor
		logic [7:0] b;
		@(negedge clk);
		if (rstn === 1'b1 && txd === 1'b0) begin
			in_frame = 1'b1;
			repeat (bit_cycles / 2) @(negedge clk);
			if (txd !== 1'b0) begin
				report_failure("Start bit on txd ended early");
			end else begin
				for (int i = 0; i < 8; i++) begin
					repeat (bit_cycles) @(negedge clk);
					b[i] = txd;
				end
				repeat (bit_cycles) @(negedge clk);
				if (txd !== 1'b1)
					report_failure("Stop bit on txd was low");
				rx_q.push_back(b);
			end
			in_frame = 1'b0;
		end
	end

	// Line idles while stalled, and led freezes once halted
	always @(negedge clk) begin
		if (rstn !== 1'b1) begin
			was_halted <= 1'b0;
		end else begin
			if (led[7:6] == mode_stall)
				compare_value("txd in stall mode", txd, 1'b1);
			if (was_halted)
				compare_value("led in halt mode", led, halt_led);
			was_halted <= (led[7:6] == mode_halt);
			halt_led <= led;
		end
	end

	// ======================================================================
	// Tests
	// ======================================================================
	task automatic handshake();
		logic [7:0] noise;
		apply_reset();
		for (int n = 0; n < 3; n++) begin
			noise = 8'($urandom);
			if (noise == start_byte)
				noise = 8'h55;
			send_byte(noise);
			repeat (bit_cycles) @(negedge clk);
			compare_value("led mode during noise", led[7:6], mode_stall);
		end
		compare_value("bytes sent before start", rx_q.size(), 0);
		prog.delete();
		expect_q.delete();
		prog.push_back(halt_word());
		run_program();
	endtask

	task automatic alu_results();
		logic [15:0] i1, i2, i3;
		logic [31:0] r1, r2, r3;
		apply_reset();
		i1 = 16'($urandom);
		i2 = 16'($urandom);
		i3 = 16'($urandom);
		r1 = sext16(i1);
		r2 = sext16(i2);
		r3 = r1 + sext16(i3);
		prog.delete();
		expect_q.delete();
		prog.push_back(imm_form(op_addi, 5'd1, 5'd0, i1));
		prog.push_back(out_word(5'd1));
		prog.push_back(imm_form(op_addi, 5'd2, 5'd0, i2));
		prog.push_back(out_word(5'd2));
		prog.push_back(imm_form(op_addi, 5'd3, 5'd1, i3));
		prog.push_back(out_word(5'd3));
		prog.push_back(reg_form(op_add, 5'd4, 5'd1, 5'd2));
		prog.push_back(out_word(5'd4));
		prog.push_back(reg_form(op_sub, 5'd5, 5'd1, 5'd2));
		prog.push_back(out_word(5'd5));
		prog.push_back(reg_form(op_and, 5'd6, 5'd1, 5'd3));
		prog.push_back(out_word(5'd6));
		prog.push_back(reg_form(op_or, 5'd7, 5'd2, 5'd3));
		prog.push_back(out_word(5'd7));
		prog.push_back(halt_word());
		expect_q.push_back(r1[7:0]);
		expect_q.push_back(r2[7:0]);
		expect_q.push_back(r3[7:0]);
		expect_q.push_back(8'(r1 + r2));
		expect_q.push_back(8'(r1 - r2));
		expect_q.push_back(8'(r1 & r3));
		expect_q.push_back(8'(r2 | r3));
		run_program();
	endtask

	task automatic zero_register();
		apply_reset();
		prog.delete();
		expect_q.delete();
		prog.push_back(imm_form(op_addi, 5'd0, 5'd0, 16'h005a));
		prog.push_back(out_word(5'd0));
		prog.push_back(halt_word());
		expect_q.push_back(8'h00);
		run_program();
	endtask

	task automatic control_flow();
		int k;
		apply_reset();
		k = 1 + $urandom % 9;
		prog.delete();
		expect_q.delete();
		prog.push_back(imm_form(op_addi, 5'd1, 5'd0, 16'(k)));
		prog.push_back(out_word(5'd1));
		prog.push_back(imm_form(op_addi, 5'd1, 5'd1, 16'hffff));
		// Back to address 1 while r1 is nonzero
		prog.push_back(imm_form(op_bne, 5'd1, 5'd0, 16'hfffd));
		prog.push_back(imm_form(op_j, 5'd0, 5'd0, 16'd6));
		prog.push_back(out_word(5'd1));
		prog.push_back(imm_form(op_addi, 5'd2, 5'd0, 16'h007e));
		prog.push_back(out_word(5'd2));
		prog.push_back(imm_form(op_beq, 5'd0, 5'd0, 16'd1));
		prog.push_back(out_word(5'd1));
		prog.push_back(halt_word());
		for (int j = k; j >= 1; j--)
			expect_q.push_back(8'(j));
		expect_q.push_back(8'h7e);
		run_program();
	endtask

	task automatic back_pressure();
		logic [7:0] vals [4];
		apply_reset();
		prog.delete();
		expect_q.delete();
		for (int i = 0; i < 4; i++) begin
			vals[i] = 8'($urandom);
			prog.push_back(imm_form(op_addi, 5'(i + 1), 5'd0, {8'd0, vals[i]}));
		end
		for (int i = 0; i < 4; i++) begin
			prog.push_back(out_word(5'(i + 1)));
			expect_q.push_back(vals[i]);
		end
		prog.push_back(out_word(5'd1));
		expect_q.push_back(vals[0]);
		prog.push_back(halt_word());
		run_program();
	endtask

	task automatic halt_hold();
		int h;
		apply_reset();
		h = 3 + $urandom % 4;
		prog.delete();
		expect_q.delete();
		for (int n = 0; n < h; n++)
			prog.push_back(imm_form(op_addi, 5'(n + 1), 5'd0, 16'(n)));
		prog.push_back(halt_word());
		// Loaded past the HALT, must never run
		prog.push_back(out_word(5'd1));
		run_program();
		compare_value("led mode", led[7:6], mode_halt);
		compare_value("led pc", led[5:0], 6'(h));
		repeat (200) begin
			@(negedge clk);
			compare_value("txd after halt", txd, 1'b1);
			compare_value("led after halt", led, {mode_halt, 6'(h)});
		end
	endtask

	initial begin
		clk = 1'b0;
		rstn = 1'b0;
		rxd = 1'b1;
		void'($urandom(32'hd7ba));
		handshake();
		alu_results();
		zero_register();
		control_flow();
		back_pressure();
		halt_hold();
		$display("Run complete: %0d value errors, %0d other errors", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
logic/cpu_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/inst_loader.sv
logic/decode.sv
logic/execute.sv
logic/cpu_top.sv
bench/tb_cpu_top.sv

// ==== logic/cpu_pkg.sv ====
/* Shared types and sizes for the serially loaded multi-cycle CPU */
`default_nettype none

package cpu_pkg;

	// ======================================================================
	// Sizes and constants
	// ======================================================================
	localparam int xlen = 32;
	localparam int imem_depth = 256;
	localparam int imem_aw = 8;
	localparam logic [7:0] start_byte = 8'hAA;

	// ======================================================================
	// Encodings
	// ======================================================================
	// Opcode lives in inst[31:26], unlisted values run as a no-op
	typedef enum logic [5:0] {
		op_add  = 6'h00,
		op_sub  = 6'h01,
		op_and  = 6'h02,
		op_or   = 6'h03,
		op_addi = 6'h04,
		op_beq  = 6'h05,
		op_bne  = 6'h06,
		op_j    = 6'h07,
		op_out  = 6'h08,
		op_halt = 6'h3f
	} opcode_t;

	typedef enum logic [1:0] {
		mode_stall = 2'd0,
		mode_load  = 2'd1,
		mode_exec  = 2'd2,
		mode_halt  = 2'd3
	} mode_t;

	typedef enum logic [1:0] {
		ph_fetch   = 2'd0,
		ph_decode  = 2'd1,
		ph_execute = 2'd2,
		ph_write   = 2'd3
	} phase_t;

	// ======================================================================
	// Stage payloads
	// ======================================================================
	typedef struct packed {
		logic [imem_aw-1:0] pc;
		logic [xlen-1:0] inst;
	} fd_t;

	typedef struct packed {
		opcode_t op;
		logic [4:0] rd;
		logic [xlen-1:0] a;
		// rt value, or rd value for branches
		logic [xlen-1:0] b;
		logic [xlen-1:0] imm;
		logic [imem_aw-1:0] pc;
	} de_t;

	typedef struct packed {
		logic we;
		logic [4:0] rd;
		logic [xlen-1:0] data;
	} ew_t;

	typedef struct packed {
		logic start;
		logic [7:0] data;
	} tx_req_t;

endpackage

`default_nettype wire

// ==== logic/cpu_top.sv ====
/* CPU top: mode and phase control, stage registers, UART links and led */
`default_nettype none
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
	parameter int clk_per_bit = 868
) (
	input logic clk,
	input logic rstn,
	input logic rxd,
	output logic txd,
	output logic [7:0] led
);

	logic [15:0] bit_cycles;
	logic [7:0] rx_byte;
	logic rx_valid;
	logic tx_busy;
	tx_req_t echo_req;
	tx_req_t ex_tx;
	tx_req_t tx_req;

	logic load_en;
	logic load_done;
	logic [xlen-1:0] inst;

	mode_t mode;
	phase_t phase;
	logic [imem_aw-1:0] pc;
	fd_t fd_r;
	de_t de_d;
	de_t de_r;
	ew_t ew_d;
	ew_t ew_r;

	logic ex_start;
	logic ex_done;
	logic [imem_aw-1:0] ex_npc;
	logic wb_en;

	assign bit_cycles = 16'(clk_per_bit);

	// ======================================================================
	// Serial links and datapath blocks
	// ======================================================================
	uart_rx u_rx (
		.clk(clk), .rstn(rstn), .rxd(rxd), .clk_per_bit(bit_cycles),
		.rx_byte(rx_byte), .rx_valid(rx_valid)
	);

	// Echo only happens in stall mode, execute owns the line afterwards
	assign echo_req.start = (mode == mode_stall) && rx_valid && (rx_byte == start_byte);
	assign echo_req.data = start_byte;
	assign tx_req = (mode == mode_stall) ? echo_req : ex_tx;

	uart_tx u_tx (
		.clk(clk), .rstn(rstn), .clk_per_bit(bit_cycles), .req(tx_req),
		.txd(txd), .busy(tx_busy)
	);

	assign load_en = (mode == mode_load);

	inst_loader u_loader (
		.clk(clk), .rstn(rstn), .load_en(load_en), .rx_byte(rx_byte),
		.rx_valid(rx_valid), .pc(pc), .inst(inst), .load_done(load_done)
	);

	assign wb_en = (mode == mode_exec) && (phase == ph_write);

	decode u_decode (
		.clk(clk), .rstn(rstn), .fd(fd_r), .wb_en(wb_en), .wb(ew_r), .de(de_d)
	);

	execute u_execute (
		.clk(clk), .rstn(rstn), .start(ex_start), .de(de_r), .tx_busy(tx_busy),
		.done(ex_done), .npc(ex_npc), .ew(ew_d), .tx(ex_tx)
	);

	// ======================================================================
	// Mode and phase controller
	// ======================================================================
	always_ff @(posedge clk) begin
		if (!rstn) begin
			mode <= mode_stall;
			phase <= ph_fetch;
			pc <= '0;
			ex_start <= 1'b0;
		end else begin
			ex_start <= (mode == mode_exec) && (phase == ph_decode);
			case (mode)
				mode_stall: if (echo_req.start) mode <= mode_load;
				mode_load: if (load_done && !tx_busy) mode <= mode_exec;
				mode_exec: begin
					case (phase)
						ph_fetch: phase <= ph_decode;
						ph_decode: phase <= ph_execute;
						ph_execute: begin
							if (ex_done) begin
								pc <= ex_npc;
								phase <= ph_write;
							end
						end
						ph_write: begin
							phase <= ph_fetch;
							if (de_r.op == op_halt)
								mode <= mode_halt;
						end
						default: phase <= ph_fetch;
					endcase
				end
				default: ;
			endcase
		end
	end

	// Stage registers
	always_ff @(posedge clk) begin
		if (mode == mode_exec) begin
			if (phase == ph_fetch)
				fd_r <= '{pc: pc, inst: inst};
			if (phase == ph_decode)
				de_r <= de_d;
			if (phase == ph_execute && ex_done)
				ew_r <= ew_d;
		end
	end

	assign led = {mode, pc[5:0]};

endmodule

`default_nettype wire

// ==== logic/decode.sv ====
/* Instruction decoder and 32-entry register file with its write-back port */
`default_nettype none
`timescale 1ns/1ps

module decode import cpu_pkg::*; (
	input logic clk,
	input logic rstn,
	input fd_t fd,
	input logic wb_en,
	input ew_t wb,
	output de_t de
);

	logic [xlen-1:0] regs [32];

	opcode_t op;
	logic [4:0] rd;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] bsel;
	logic is_branch;

	// ======================================================================
	// Field split
	// ======================================================================
	assign op = opcode_t'(fd.inst[31:26]);
	assign rd = fd.inst[25:21];
	assign rs = fd.inst[20:16];
	assign rt = fd.inst[15:11];

	// Branches compare rd with rs, so rd goes out on the b port
	assign is_branch = (op == op_beq) || (op == op_bne);
	assign bsel = is_branch ? rd : rt;

	always_comb begin
		de.op = op;
		de.rd = rd;
		de.a = (rs == 5'd0) ? '0 : regs[rs];
		de.b = (bsel == 5'd0) ? '0 : regs[bsel];
		de.imm = {{16{fd.inst[15]}}, fd.inst[15:0]};
		de.pc = fd.pc;
	end

	// ======================================================================
	// Register file
	// ======================================================================
	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wb_en && wb.we && (wb.rd != 5'd0)) begin
			regs[wb.rd] <= wb.data;
		end
	end

endmodule

`default_nettype wire

// ==== logic/execute.sv ====
/* Execute stage: ALU, branch and jump target, and OUT requests held
   until the transmitter is free */
`default_nettype none
`timescale 1ns/1ps

module execute import cpu_pkg::*; (
	input logic clk,
	input logic rstn,
	input logic start,
	input de_t de,
	input logic tx_busy,
	output logic done,
	output logic [imem_aw-1:0] npc,
	output ew_t ew,
	output tx_req_t tx
);

	typedef enum logic {ex_idle, ex_wait} ex_state_t;

	ex_state_t state;
	logic is_out;
	logic out_go;
	logic taken;
	logic [imem_aw-1:0] pc_inc;

	assign is_out = (de.op == op_out);
	assign out_go = (start || (state == ex_wait)) && is_out && !tx_busy;

	// OUT parks here while a previous frame is still on the line
	always_ff @(posedge clk) begin
		if (!rstn)
			state <= ex_idle;
		else if (start && is_out && tx_busy)
			state <= ex_wait;
		else if (out_go)
			state <= ex_idle;
	end

	always_comb begin
		pc_inc = de.pc + 1'b1;
		npc = pc_inc;
		taken = 1'b0;
		ew.we = 1'b0;
		ew.rd = de.rd;
		ew.data = '0;
		case (de.op)
			op_add: begin
				ew.we = 1'b1;
				ew.data = de.a + de.b;
			end
			op_sub: begin
				ew.we = 1'b1;
				ew.data = de.a - de.b;
			end
			op_and: begin
				ew.we = 1'b1;
				ew.data = de.a & de.b;
			end
			op_or: begin
				ew.we = 1'b1;
				ew.data = de.a | de.b;
			end
			op_addi: begin
				ew.we = 1'b1;
				ew.data = de.a + de.imm;
			end
			op_beq: taken = (de.a == de.b);
			op_bne: taken = (de.a != de.b);
			op_j: npc = de.imm[imem_aw-1:0];
			// pc stays on the HALT itself
			op_halt: npc = de.pc;
			default: ;
		endcase
		if (taken)
			npc = pc_inc + de.imm[imem_aw-1:0];

		done = is_out ? out_go : start;
		tx.start = out_go;
		tx.data = de.a[7:0];
	end

endmodule

`default_nettype wire

// ==== logic/inst_loader.sv ====
/* Program loader: count byte then little-endian words into instruction memory,
   with a combinational read port at pc */
`default_nettype none
`timescale 1ns/1ps

module inst_loader import cpu_pkg::*; (
	input logic clk,
	input logic rstn,
	input logic load_en,
	input logic [7:0] rx_byte,
	input logic rx_valid,
	input logic [imem_aw-1:0] pc,
	output logic [xlen-1:0] inst,
	output logic load_done
);

	logic [xlen-1:0] mem [imem_depth];

	logic have_count;
	logic [imem_aw-1:0] count;
	logic [imem_aw-1:0] wr_addr;
	logic [1:0] byte_idx;
	logic [23:0] word_buf;
	logic take;
	logic word_wr;

	assign load_done = have_count && (wr_addr == count);
	assign take = load_en && rx_valid && !load_done;
	assign word_wr = take && have_count && (byte_idx == 2'd3);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			have_count <= 1'b0;
			count <= '0;
			wr_addr <= '0;
			byte_idx <= '0;
		end else if (take) begin
			if (!have_count) begin
				have_count <= 1'b1;
				count <= rx_byte;
			end else begin
				byte_idx <= byte_idx + 2'd1;
				if (word_wr)
					wr_addr <= wr_addr + 1'b1;
			end
		end
	end

	// Byte assembly and memory write
	always_ff @(posedge clk) begin
		if (take && have_count)
			word_buf <= {rx_byte, word_buf[23:8]};
		if (word_wr)
			mem[wr_addr] <= {rx_byte, word_buf};
	end

	// Anything past the loaded program reads as HALT
	assign inst = (pc < wr_addr) ? mem[pc] : {op_halt, 26'd0};

endmodule

`default_nettype wire

// ==== logic/uart_rx.sv ====
/* 8N1 serial receiver, one byte out with a single-cycle valid strobe */
`default_nettype none
`timescale 1ns/1ps

module uart_rx (
	input logic clk,
	input logic rstn,
	input logic rxd,
	input logic [15:0] clk_per_bit,
	output logic [7:0] rx_byte,
	output logic rx_valid
);

	typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;

	rx_state_t state;
	logic [1:0] rxd_sync;
	logic [15:0] cnt;
	logic [2:0] nbit;
	logic [7:0] shift;

	assign rx_byte = shift;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= rx_idle;
			rxd_sync <= 2'b11;
			cnt <= '0;
			nbit <= '0;
			rx_valid <= 1'b0;
		end else begin
			rxd_sync <= {rxd_sync[0], rxd};
			rx_valid <= 1'b0;
			case (state)
				rx_idle: begin
					cnt <= '0;
					nbit <= '0;
					if (!rxd_sync[1])
						state <= rx_start;
				end
				// Recheck the line half a bit in, to reject glitches
				rx_start: begin
					if (cnt == {1'b0, clk_per_bit[15:1]}) begin
						cnt <= '0;
						state <= rxd_sync[1] ? rx_idle : rx_data;
					end else begin
						cnt <= cnt + 16'd1;
					end
				end
				rx_data: begin
					if (cnt == clk_per_bit - 16'd1) begin
						cnt <= '0;
						shift <= {rxd_sync[1], shift[7:1]};
						nbit <= nbit + 3'd1;
						if (nbit == 3'd7)
							state <= rx_stop;
					end else begin
						cnt <= cnt + 16'd1;
					end
				end
				rx_stop: begin
					if (cnt == clk_per_bit - 16'd1) begin
						state <= rx_idle;
						rx_valid <= rxd_sync[1];
					end else begin
						cnt <= cnt + 16'd1;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
/* 8N1 serial transmitter, started by a request strobe while idle */
`default_nettype none
`timescale 1ns/1ps

module uart_tx import cpu_pkg::*; (
	input logic clk,
	input logic rstn,
	input logic [15:0] clk_per_bit,
	input tx_req_t req,
	output logic txd,
	output logic busy
);

	// Data bits then the stop bit, LSB first
	logic [8:0] shift;
	logic [15:0] cnt;
	logic [3:0] nbits;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			busy <= 1'b0;
			txd <= 1'b1;
			cnt <= '0;
			nbits <= '0;
		end else if (!busy) begin
			if (req.start) begin
				busy <= 1'b1;
				txd <= 1'b0;
				shift <= {1'b1, req.data};
				cnt <= '0;
				nbits <= '0;
			end
		end else if (cnt == clk_per_bit - 16'd1) begin
			cnt <= '0;
			if (nbits == 4'd9) begin
				// End of stop bit
				busy <= 1'b0;
			end else begin
				txd <= shift[0];
				shift <= {1'b1, shift[8:1]};
				nbits <= nbits + 4'd1;
			end
		end else begin
			cnt <= cnt + 16'd1;
		end
	end

endmodule

`default_nettype wire
